// File: run.sh
#!/bin/sh
# build and run the pci_multi testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module pci_multi_tb -o sim_pci_multi
./obj_dir/sim_pci_multi > sim.log 2>&1 || true
cat sim.log
if grep -q "^TEST OK$" sim.log; then
	exit 0
fi
exit 1

// File: src/pci_bus_merge.sv
`timescale 1ns/1ns

module pci_bus_merge #(
	parameter int NUM_FUNC = 3
) (
	input logic clk_i,
	input logic arst_n_i,
	input pci_multi_pkg::func_drive_t drive_i [NUM_FUNC],
	input logic [3:0] cbe_n_i,
	output logic [31:0] ad_o,
	output logic ad_oe_o,
	output logic devsel_n_o,
	output logic trdy_n_o,
	output logic par_o,
	output logic par_oe_o
);

	pci_multi_pkg::func_drive_t sel;
	logic any_claim;

	// walk down so the lowest claiming index is the one left in sel.
	always_comb
	begin
		sel = '0;
		any_claim = 1'b0;
		for (int i = NUM_FUNC - 1; i >= 0; i--)
		begin
			if (drive_i[i].claim)
				sel = drive_i[i];
			any_claim = any_claim | drive_i[i].claim;
		end
	end

	assign ad_o = sel.ad;
	assign ad_oe_o = sel.ad_oe;
	assign trdy_n_o = !sel.ready;
	assign devsel_n_o = !any_claim;

	// parity covers ad and c/be of the previous clock.
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			par_o <= 1'b0;
			par_oe_o <= 1'b0;
		end
		else
		begin
			par_o <= ^{ad_o, cbe_n_i};
			par_oe_o <= ad_oe_o;
		end
	end

endmodule

// File: src/pci_bus_sampler.sv
`timescale 1ns/1ns

module pci_bus_sampler (
	input logic clk_i,
	input logic arst_n_i,
	input logic frame_n_i,
	input logic irdy_n_i,
	input logic idsel_i,
	input logic [3:0] cbe_n_i,
	input logic [31:0] ad_i,
	output pci_multi_pkg::addr_phase_t addr_o,
	output pci_multi_pkg::data_phase_t data_o
);

	logic frame_n_q;
	logic new_addr;
	logic addr_valid_q;
	pci_multi_pkg::pci_cmd_e addr_cmd_q;
	logic addr_idsel_q;
	pci_multi_pkg::pci_addr_u addr_word_q;
	logic irdy_q;
	logic last_q;
	logic [3:0] be_q;
	logic [31:0] wdata_q;

	assign new_addr = !frame_n_i && frame_n_q; // frame falling edge.

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			frame_n_q <= 1'b1;
			addr_valid_q <= 1'b0;
			irdy_q <= 1'b0;
			last_q <= 1'b1;
		end
		else
		begin
			frame_n_q <= frame_n_i;
			addr_valid_q <= new_addr;
			irdy_q <= !irdy_n_i;
			last_q <= frame_n_i;
		end
	end

	// address fields stay put until the next address phase.
	always_ff @(posedge clk_i)
	begin
		if (new_addr)
		begin
			addr_cmd_q <= pci_multi_pkg::pci_cmd_e'(cbe_n_i);
			addr_idsel_q <= idsel_i;
			addr_word_q <= ad_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		be_q <= ~cbe_n_i;
		wdata_q <= ad_i;
	end

	always_comb
	begin
		addr_o.valid = addr_valid_q;
		addr_o.cmd = addr_cmd_q;
		addr_o.idsel = addr_idsel_q;
		addr_o.addr = addr_word_q;
	end

	always_comb
	begin
		data_o.irdy = irdy_q;
		data_o.last = last_q;
		data_o.be = be_q;
		data_o.wdata = wdata_q;
	end

endmodule

// File: src/pci_func_target.sv
`timescale 1ns/1ns

module pci_func_target #(
	parameter logic [15:0] VENDOR_ID = 16'h1234,
	parameter logic [15:0] DEVICE_ID_BASE = 16'h0100,
	parameter int FUNC_NUM = 0
) (
	input logic clk_i,
	input logic arst_n_i,
	input pci_multi_pkg::addr_phase_t addr_i,
	input pci_multi_pkg::data_phase_t data_i,
	output pci_multi_pkg::func_drive_t drive_o
);

	localparam logic [15:0] DEVICE_ID = DEVICE_ID_BASE + 16'(FUNC_NUM);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CLAIMED,
		ST_DONE
	} state_e;

	state_e state_q;
	logic armed_q;
	logic [15:0] cmd_q;
	logic [27:0] bar_q;
	logic [31:0] mem_q [4];
	logic [31:0] rdata_q;
	logic is_cfg;
	logic is_mem;
	logic is_write;
	logic cfg_hit;
	logic mem_hit;
	logic done_now;
	logic active;
	logic [31:0] cfg_rdata;
	logic [31:0] rdata;
	logic [31:0] cmd_wr;
	logic [31:0] bar_wr;
	logic [31:0] mem_wr;

	function automatic logic [31:0] be_merge(
		input logic [31:0] old_val,
		input logic [31:0] new_val,
		input logic [3:0] be
	);
		logic [31:0] res;
		res = old_val;
		for (int b = 0; b < 4; b++)
		begin
			if (be[b])
				res[b*8 +: 8] = new_val[b*8 +: 8];
		end
		return res;
	endfunction

	always_comb
	begin
		is_cfg = (addr_i.cmd == pci_multi_pkg::CMD_CFG_READ) ||
			(addr_i.cmd == pci_multi_pkg::CMD_CFG_WRITE);
		is_mem = (addr_i.cmd == pci_multi_pkg::CMD_MEM_READ) ||
			(addr_i.cmd == pci_multi_pkg::CMD_MEM_WRITE);
		is_write = (addr_i.cmd == pci_multi_pkg::CMD_CFG_WRITE) ||
			(addr_i.cmd == pci_multi_pkg::CMD_MEM_WRITE);
		cfg_hit = is_cfg && addr_i.idsel && (addr_i.addr.cfg.cfg_type == 2'b00) &&
			(addr_i.addr.cfg.func_num == 3'(FUNC_NUM));
		mem_hit = is_mem && cmd_q[pci_multi_pkg::CMD_MEM_EN_BIT] &&
			(addr_i.addr.mem.base == bar_q);
	end

	always_comb
	begin
		case (addr_i.addr.cfg.reg_num)
			pci_multi_pkg::CFG_REG_ID: cfg_rdata = {DEVICE_ID, VENDOR_ID};
			pci_multi_pkg::CFG_REG_CMD: cfg_rdata = {16'h0000, cmd_q};
			pci_multi_pkg::CFG_REG_BAR0: cfg_rdata = {bar_q, 4'h0};
			default: cfg_rdata = 32'h0;
		endcase
		rdata = is_cfg ? cfg_rdata : mem_q[addr_i.addr.mem.reg_idx];
	end

	// merged write values under the byte enables of the data phase.
	always_comb
	begin
		cmd_wr = be_merge({16'h0000, cmd_q}, data_i.wdata, data_i.be);
		bar_wr = be_merge({bar_q, 4'h0}, data_i.wdata, data_i.be);
		mem_wr = be_merge(mem_q[addr_i.addr.mem.reg_idx], data_i.wdata, data_i.be);
	end

	// data_i lags the bus by one cycle, so the sampled irdy only counts once trdy
	// was already low at that edge. the drive drops as soon as it shows up.
	assign done_now = (state_q == ST_CLAIMED) && armed_q && data_i.irdy && data_i.last;
	assign active = (state_q == ST_CLAIMED) && !done_now;

	always_comb
	begin
		drive_o.claim = active;
		drive_o.ready = active;
		drive_o.ad_oe = active && !is_write;
		drive_o.ad = rdata_q;
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= ST_IDLE;
			armed_q <= 1'b0;
			cmd_q <= 16'h0000;
			bar_q <= 28'h0;
			for (int r = 0; r < 4; r++)
				mem_q[r] <= 32'h0;
		end
		else
		begin
			armed_q <= (state_q == ST_CLAIMED); // trdy was low at this edge.
			case (state_q)
				ST_IDLE:
				begin
					if (addr_i.valid && (cfg_hit || mem_hit))
						state_q <= ST_CLAIMED;
				end
				ST_CLAIMED:
				begin
					if (done_now)
					begin
						state_q <= ST_DONE;
						if (is_write && is_cfg)
						begin
							if (addr_i.addr.cfg.reg_num == pci_multi_pkg::CFG_REG_CMD)
								cmd_q <= cmd_wr[15:0];
							else if (addr_i.addr.cfg.reg_num == pci_multi_pkg::CFG_REG_BAR0)
								bar_q <= bar_wr[31:4];
						end
						else if (is_write)
							mem_q[addr_i.addr.mem.reg_idx] <= mem_wr;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (addr_i.valid)
			rdata_q <= rdata; // held for the whole data phase.
	end

endmodule

// File: src/pci_multi.sv
`timescale 1ns/1ns

module pci_multi #(
	parameter int NUM_FUNC = 3,
	parameter logic [15:0] VENDOR_ID = 16'h1234,
	parameter logic [15:0] DEVICE_ID_BASE = 16'h0100
) (
	input logic clk_i,
	input logic arst_n_i,
	input logic frame_n_i,
	input logic irdy_n_i,
	input logic idsel_i,
	input logic [3:0] cbe_n_i,
	input logic [31:0] ad_i,
	output logic [31:0] ad_o,
	output logic ad_oe_o,
	output logic devsel_n_o,
	output logic trdy_n_o,
	output logic par_o,
	output logic par_oe_o
);

	pci_multi_pkg::addr_phase_t addr_phase;
	pci_multi_pkg::data_phase_t data_phase;
	pci_multi_pkg::func_drive_t func_drive [NUM_FUNC];

	pci_bus_sampler u_sampler (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.frame_n_i(frame_n_i),
		.irdy_n_i(irdy_n_i),
		.idsel_i(idsel_i),
		.cbe_n_i(cbe_n_i),
		.ad_i(ad_i),
		.addr_o(addr_phase),
		.data_o(data_phase)
	);

	for (genvar g = 0; g < NUM_FUNC; g++)
	begin : g_func
		pci_func_target #(
			.VENDOR_ID(VENDOR_ID),
			.DEVICE_ID_BASE(DEVICE_ID_BASE),
			.FUNC_NUM(g)
		) u_func (
			.clk_i(clk_i),
			.arst_n_i(arst_n_i),
			.addr_i(addr_phase),
			.data_i(data_phase),
			.drive_o(func_drive[g])
		);
	end

	pci_bus_merge #(
		.NUM_FUNC(NUM_FUNC)
	) u_merge (
		.clk_i(clk_i),
		.arst_n_i(arst_n_i),
		.drive_i(func_drive),
		.cbe_n_i(cbe_n_i),
		.ad_o(ad_o),
		.ad_oe_o(ad_oe_o),
		.devsel_n_o(devsel_n_o),
		.trdy_n_o(trdy_n_o),
		.par_o(par_o),
		.par_oe_o(par_oe_o)
	);

endmodule

// File: src/pci_multi_pkg.sv
package pci_multi_pkg;

	// bus commands decoded by the targets, taken from C/BE# in the address phase.
	typedef enum logic [3:0] {
		CMD_MEM_READ = 4'b0110,
		CMD_MEM_WRITE = 4'b0111,
		CMD_CFG_READ = 4'b1010,
		CMD_CFG_WRITE = 4'b1011
	} pci_cmd_e;

	// configuration dword numbers
	localparam logic [5:0] CFG_REG_ID = 6'd0; // device id and vendor id.
	localparam logic [5:0] CFG_REG_CMD = 6'd1; // command, status reads zero.
	localparam logic [5:0] CFG_REG_BAR0 = 6'd4; // 16-byte memory window.

	localparam int CMD_MEM_EN_BIT = 1;

	typedef struct packed {
		logic [20:0] rsvd;
		logic [2:0] func_num;
		logic [5:0] reg_num;
		logic [1:0] cfg_type; // 00 for type-0 accesses.
	} cfg_addr_t;

	typedef struct packed {
		logic [27:0] base;
		logic [1:0] reg_idx;
		logic [1:0] low;
	} mem_addr_t;

	// one AD word, read as either kind of address.
	typedef union packed {
		cfg_addr_t cfg;
		mem_addr_t mem;
	} pci_addr_u;

	typedef struct packed {
		logic valid; // pulses for one cycle per address phase.
		pci_cmd_e cmd;
		logic idsel;
		pci_addr_u addr;
	} addr_phase_t;

	typedef struct packed {
		logic irdy;
		logic last; // frame already released.
		logic [3:0] be;
		logic [31:0] wdata;
	} data_phase_t;

	typedef struct packed {
		logic claim;
		logic ready;
		logic ad_oe;
		logic [31:0] ad;
	} func_drive_t;

endpackage

// File: verif/pci_multi_checker.sv
`timescale 1ns/1ns

module pci_multi_checker (
	input logic clk_i,
	input logic arst_n_i,
	input logic txn_active_i,
	input logic exp_claim_i,
	input logic exp_read_i,
	input logic [31:0] exp_rdata_i,
	input logic [3:0] cbe_n_i,
	input logic [31:0] ad_i,
	input logic ad_oe_i,
	input logic devsel_n_i,
	input logic trdy_n_i,
	input logic par_i,
	input logic par_oe_i,
	output int error_count_o
);

	logic [31:0] prev_ad;
	logic [3:0] prev_cbe;
	logic prev_oe;
	logic exp_par;
	bit prev_valid = 0;
	bit active_q = 0;
	bit claimed = 0;
	bit flagged = 0;
	int cyc = 0;
	int txn_num = 0;
	logic [31:0] held_ad;
	logic held_oe;

	initial
		error_count_o = 0;

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		error_count_o++;
	endtask

	// all sampling on the falling edge, where bus values are settled.
	always @(negedge clk_i)
	begin
		if (arst_n_i)
		begin
			exp_par = ($countones({prev_ad, prev_cbe}) % 2) == 1; // even parity bit.
			if (par_oe_i && prev_valid && par_i !== exp_par)
				mismatch("par_o", exp_par, par_i);
			if (prev_valid && par_oe_i !== prev_oe)
				mismatch("par_oe_o", prev_oe, par_oe_i);
			prev_ad = ad_i;
			prev_cbe = cbe_n_i;
			prev_oe = ad_oe_i;
			prev_valid = 1;
			if (!txn_active_i)
			begin
				if (active_q && exp_claim_i && !claimed)
				begin
					$display("transaction %0d at %0t was never claimed by any function",
						txn_num, $time);
					error_count_o++;
				end
				if (devsel_n_i !== 1'b1)
					mismatch("devsel_n_o", 1, devsel_n_i);
				if (trdy_n_i !== 1'b1)
					mismatch("trdy_n_o", 1, trdy_n_i);
				if (ad_oe_i !== 1'b0)
					mismatch("ad_oe_o", 0, ad_oe_i);
			end
			else
			begin
				if (!active_q)
				begin
					cyc = 0;
					claimed = 0;
					flagged = 0;
					txn_num++;
				end
				cyc++;
				if (!devsel_n_i)
				begin
					if (!exp_claim_i && !flagged)
					begin
						$display("transaction %0d at %0t was claimed, none expected",
							txn_num, $time);
						error_count_o++;
						flagged = 1;
					end
					if (trdy_n_i !== 1'b0)
						mismatch("trdy_n_o", 0, trdy_n_i);
					if (!claimed)
					begin
						claimed = 1;
						held_ad = ad_i;
						held_oe = ad_oe_i;
						if (cyc != 3)
							mismatch("devsel_n_o claim cycle", 3, cyc);
						if (exp_claim_i && ad_oe_i !== exp_read_i)
							mismatch("ad_oe_o", exp_read_i, ad_oe_i);
						if (exp_claim_i && exp_read_i && ad_i !== exp_rdata_i)
							mismatch("ad_o", exp_rdata_i, ad_i);
					end
					else
					begin
						if (ad_i !== held_ad)
							mismatch("ad_o held", held_ad, ad_i);
						if (ad_oe_i !== held_oe)
							mismatch("ad_oe_o held", held_oe, ad_oe_i);
					end
				end
				else
				begin
					if (claimed)
						mismatch("devsel_n_o held", 0, devsel_n_i);
					if (trdy_n_i !== 1'b1)
						mismatch("trdy_n_o", 1, trdy_n_i);
				end
			end
			active_q = txn_active_i;
		end
	end

endmodule

// File: verif/pci_multi_tb.sv
`timescale 1ns/1ns

module pci_multi_tb;

	localparam int NUM_FUNC = 3;
	localparam logic [15:0] VENDOR_ID = 16'h10ee;
	localparam logic [15:0] DEVICE_ID_BASE = 16'h7020;
	localparam int FIELDS = 7; // cmd idsel addr be wdata rdata claim.
	localparam int MAX_TXN = 64;

	logic clk;
	logic arst_n;
	logic frame_n;
	logic irdy_n;
	logic idsel;
	logic [3:0] cbe_n;
	logic [31:0] ad;
	logic [31:0] ad_o;
	logic ad_oe_o;
	logic devsel_n_o;
	logic trdy_n_o;
	logic par_o;
	logic par_oe_o;

	logic txn_active;
	logic exp_claim;
	logic exp_read;
	logic [31:0] exp_rdata;
	int chk_errors;

	logic [31:0] td [FIELDS*MAX_TXN];
	int num_txn;
	int limit = 1000000;
	int cycle_cnt = 0;
	logic [31:0] lcg_state = 32'hbc29;

	pci_multi #(
		.NUM_FUNC(NUM_FUNC),
		.VENDOR_ID(VENDOR_ID),
		.DEVICE_ID_BASE(DEVICE_ID_BASE)
	) u_dut (
		.clk_i(clk),
		.arst_n_i(arst_n),
		.frame_n_i(frame_n),
		.irdy_n_i(irdy_n),
		.idsel_i(idsel),
		.cbe_n_i(cbe_n),
		.ad_i(ad),
		.ad_o(ad_o),
		.ad_oe_o(ad_oe_o),
		.devsel_n_o(devsel_n_o),
		.trdy_n_o(trdy_n_o),
		.par_o(par_o),
		.par_oe_o(par_oe_o)
	);

	pci_multi_checker u_chk (
		.clk_i(clk),
		.arst_n_i(arst_n),
		.txn_active_i(txn_active),
		.exp_claim_i(exp_claim),
		.exp_read_i(exp_read),
		.exp_rdata_i(exp_rdata),
		.cbe_n_i(cbe_n),
		.ad_i(ad_o),
		.ad_oe_i(ad_oe_o),
		.devsel_n_i(devsel_n_o),
		.trdy_n_i(trdy_n_o),
		.par_i(par_o),
		.par_oe_i(par_oe_o),
		.error_count_o(chk_errors)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= limit)
		begin
			$display("timeout after %0d cycles, a transaction never completed", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	// one transaction: address phase, data phase with wait states, then release.
	task automatic run_txn(input int t);
		logic [3:0] cmd;
		logic [3:0] be;
		int waits;
		int cyc;
		bit seen;
		bit done;
		bit completing;
		bit abort;
		cmd = td[t*FIELDS][3:0];
		be = td[t*FIELDS+3][3:0];
		lcg_state = lcg_next(lcg_state);
		waits = int'(lcg_state[17:16]); // 0 to 3 wait states.
		seen = 0;
		done = 0;
		cyc = 0;
		exp_claim <= td[t*FIELDS+6][0];
		exp_read <= !cmd[0];
		exp_rdata <= td[t*FIELDS+5];
		txn_active <= 1'b1;
		frame_n <= 1'b0;
		cbe_n <= cmd;
		ad <= td[t*FIELDS+2];
		idsel <= td[t*FIELDS+1][0];
		irdy_n <= 1'b1;
		@(posedge clk);
		frame_n <= 1'b1;
		idsel <= 1'b0;
		cbe_n <= ~be;
		ad <= cmd[0] ? td[t*FIELDS+4] : 32'h0;
		irdy_n <= (waits == 0) ? 1'b0 : 1'b1;
		while (!done)
		begin
			@(negedge clk);
			cyc++;
			if (!devsel_n_o)
				seen = 1;
			completing = !irdy_n && !trdy_n_o;
			abort = !seen && cyc >= 4; // master abort.
			@(posedge clk);
			if (completing || abort)
			begin
				irdy_n <= 1'b1;
				cbe_n <= 4'hf;
				ad <= 32'h0;
				txn_active <= 1'b0;
				done = 1;
			end
			else if (cyc >= waits)
				irdy_n <= 1'b0;
		end
		@(posedge clk); // bus idle before the next address phase.
	endtask

	initial
	begin
		frame_n = 1'b1;
		irdy_n = 1'b1;
		idsel = 1'b0;
		cbe_n = 4'hf;
		ad = 32'h0;
		arst_n = 1'b0;
		txn_active = 1'b0;
		exp_claim = 1'b0;
		exp_read = 1'b0;
		exp_rdata = 32'h0;
		for (int i = 0; i < FIELDS*MAX_TXN; i++)
			td[i] = 32'hffffffff;
		$readmemh("verif/pci_multi_testdata.txt", td);
		num_txn = 0;
		while (num_txn < MAX_TXN && td[num_txn*FIELDS] != 32'hffffffff)
			num_txn++;
		limit = num_txn * 10 + 50;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		for (int t = 0; t < num_txn; t++)
			run_txn(t);
		repeat (3) @(posedge clk);
		$display("%0d transactions, %0d errors", num_txn, chk_errors);
		if (chk_errors == 0 && num_txn > 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verif/pci_multi_testdata.txt
// cmd idsel addr be(active high) wdata exp_rdata exp_claim
// ID reads of each function
a 1 00000000 f 00000000 702010ee 1
a 1 00000100 f 00000000 702110ee 1
a 1 00000200 f 00000000 702210ee 1
// configuration decode misses
a 0 00000000 f 00000000 00000000 0
a 1 00000300 f 00000000 00000000 0
a 1 00000700 f 00000000 00000000 0
a 1 00000001 f 00000000 00000000 0
// BAR write, ID write ignored, unlisted register
b 1 00000010 f 12345678 00000000 1
a 1 00000010 f 00000000 12345670 1
b 1 00000000 f deadbeef 00000000 1
a 1 00000000 f 00000000 702010ee 1
a 1 00000008 f 00000000 00000000 1
// memory enable still clear
6 0 12345670 f 00000000 00000000 0
b 1 00000004 f 00000002 00000000 1
a 1 00000004 f 00000000 00000002 1
b 1 00000110 f 80000010 00000000 1
b 1 00000104 f 00000002 00000000 1
// memory writes and reads
7 0 12345670 f a5a5a5a5 00000000 1
7 0 1234567c f 0badf00d 00000000 1
7 0 80000014 f 11112222 00000000 1
6 0 12345670 f 00000000 a5a5a5a5 1
6 0 1234567c f 00000000 0badf00d 1
6 0 80000014 f 00000000 11112222 1
6 0 80000010 f 00000000 00000000 1
6 0 12345680 f 00000000 00000000 0
6 0 00000000 f 00000000 00000000 0
// byte enables
7 0 12345674 5 11223344 00000000 1
6 0 12345674 f 00000000 00220044 1
7 0 12345674 8 ff000000 00000000 1
6 0 12345674 f 00000000 ff220044 1
b 1 00000210 2 0000ab00 00000000 1
a 1 00000210 f 00000000 0000ab00 1
// two functions on one BAR
b 1 00000210 f 12345670 00000000 1
b 1 00000204 f 00000002 00000000 1
6 0 12345670 f 00000000 a5a5a5a5 1
7 0 12345678 f cafef00d 00000000 1
6 0 12345678 f 00000000 cafef00d 1
b 1 00000004 f 00000000 00000000 1
6 0 12345670 f 00000000 00000000 1
6 0 12345678 f 00000000 cafef00d 1

// File: vlog.f
src/pci_multi_pkg.sv
src/pci_bus_sampler.sv
src/pci_func_target.sv
src/pci_bus_merge.sv
src/pci_multi.sv
verif/pci_multi_checker.sv
verif/pci_multi_tb.sv
